//--- Makefile
VERILATOR ?= verilator
TOP       ?= socket_tb
FILELIST  ?= mini_socket.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --assert -sv --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/socket_tb.sv
`timescale 1ns/100ps
`default_nettype none

module socket_tb;

    typedef struct packed {
        socket_pkg::mem_rsp_t rsp;
        int                   due;
    } pend_t;

    logic                  clk;
    logic                  arst_n;
    logic                  dcr_wr;
    socket_pkg::dcr_req_t  dcr;
    logic                  mem_req_valid;
    socket_pkg::mem_req_t  mem_req;
    logic                  mem_ready;
    logic                  mem_rsp_valid;
    socket_pkg::mem_rsp_t  mem_rsp;
    logic                  busy;

    socket_pkg::data_t     mem [1 << socket_pkg::ADDR_W];
    pend_t                 pending [$];
    socket_pkg::mem_addr_t exp_addr [$];
    socket_pkg::data_t     exp_word [$];
    socket_pkg::mem_addr_t next_fetch [socket_pkg::NUM_CORES];
    logic                  data_due [socket_pkg::NUM_CORES];
    logic                  data_wr [socket_pkg::NUM_CORES];
    integer                seed;
    int                    cyc;
    int                    store_count;
    logic                  busy_s;
    logic                  req_s;
    logic                  stalled;
    socket_pkg::mem_req_t  stalled_req;
    int                    fd;
    int                    rc;
    logic [8*8-1:0]        kind;
    logic [8*120-1:0]      line;
    socket_pkg::data_t     fa;
    socket_pkg::data_t     fw;
    socket_pkg::mem_addr_t test_pc;
    int                    test_stores;
    logic                  done;

    socket_top i_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .dcr_wr        (dcr_wr),
        .dcr           (dcr),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
    endtask

    task automatic check_word(input socket_pkg::mem_addr_t addr,
                              input socket_pkg::data_t got, input socket_pkg::data_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("word at %03h is %04h, expected %04h", addr, got, exp));
        end
    endtask

    task automatic check_tag(input socket_pkg::mem_rsp_t rsp, input int core_idx);
        if (rsp.tag !== socket_pkg::tag_t'(core_idx)) begin
            report_mismatch($sformatf("response tag %0d, request came from core %0d",
                                      rsp.tag, core_idx));
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("busy is %b, expected %b", got, exp));
        end
    endtask

    task automatic check_req(input socket_pkg::mem_req_t got, input socket_pkg::mem_req_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("request %h changed to %h while stalled", exp, got));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            report_mismatch($sformatf("%0d stores seen, expected %0d", got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program order of each core

    function automatic logic fits_core(input socket_pkg::mem_req_t req, input int c);
        if (data_due[c]) begin
            return req.wr == data_wr[c];
        end
        return !req.wr && (req.addr == next_fetch[c]);
    endfunction

    function automatic int request_owner(input socket_pkg::mem_req_t req);
        int owner;
        owner = -1;
        for (int c = 0; c < socket_pkg::NUM_CORES; c++) begin
            if (owner < 0 && fits_core(req, c)) begin
                owner = c;
            end
        end
        // The tagged core wins when it also expects this request
        if (fits_core(req, int'(req.tag))) begin
            owner = int'(req.tag);
        end
        return owner;
    endfunction

    // Advances the expected fetch address and data access using the fetched opcode
    task automatic follow_program(input int c, input socket_pkg::mem_req_t req);
        core_pkg::opcode_t op;
        if (data_due[c]) begin
            data_due[c] = 1'b0;
        end else begin
            op            = core_pkg::opcode_t'(mem[req.addr][15:12]);
            next_fetch[c] = next_fetch[c] + 1'b1;
            data_due[c]   = (op == core_pkg::OP_LOAD) || (op == core_pkg::OP_STORE);
            data_wr[c]    = (op == core_pkg::OP_STORE);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model

    task automatic fill_memory();
        for (int a = 0; a < (1 << socket_pkg::ADDR_W); a++) begin
            mem[socket_pkg::mem_addr_t'(a)] = socket_pkg::data_t'(a) ^ 16'h05a5;
        end
    endtask

    task automatic accept_request();
        pend_t entry;
        int    owner;
        foreach (pending[i]) begin
            if (pending[i].rsp.tag == mem_req.tag) begin
                report_mismatch($sformatf("core %0d has two requests in flight", mem_req.tag));
            end
        end
        owner = request_owner(mem_req);
        if (owner < 0) begin
            report_mismatch($sformatf("request to %03h fits no core's next access",
                                      mem_req.addr));
        end
        entry.rsp.tag  = mem_req.tag;
        check_tag(entry.rsp, owner);
        follow_program(owner, mem_req);
        entry.rsp.data = mem[mem_req.addr];
        // Latency of 1 to 4 cycles after the taking edge
        entry.due      = cyc + 1 + ($random(seed) & 3);
        if (mem_req.wr) begin
            mem[mem_req.addr] = mem_req.wdata;
            entry.rsp.data    = '0;
            store_count++;
        end
        pending.push_back(entry);
    endtask

    task automatic send_response();
        int slot;
        slot = -1;
        foreach (pending[i]) begin
            if (slot < 0 && pending[i].due <= cyc) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = pending[slot].rsp;
            pending.delete(slot);
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp       = '0;
        end
    endtask

    // One clock samples the port mid cycle and drives new inputs after the edge
    task automatic tick();
        @(negedge clk);
        busy_s = busy;
        req_s  = mem_req_valid;
        if (stalled) begin
            if (!mem_req_valid) begin
                report_mismatch("request withdrawn while mem_ready was low");
            end
            check_req(mem_req, stalled_req);
        end
        stalled     = mem_req_valid && !mem_ready;
        stalled_req = mem_req;
        if (mem_req_valid && mem_ready) begin
            accept_request();
        end
        @(posedge clk);
        cyc++;
        #2;
        mem_ready = (($random(seed) & 3) != 0);
        send_response();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequences

    task automatic write_dcr(input socket_pkg::dcr_addr_t addr, input socket_pkg::data_t data);
        dcr.addr = addr;
        dcr.data = data;
        dcr_wr   = 1'b1;
        tick();
        dcr_wr   = 1'b0;
        dcr      = '0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_s && n < 2000) begin
            tick();
            n++;
        end
        if (busy_s) begin
            abort_run("Timeout: busy still high after 2000 cycles");
        end
    endtask

    task automatic run_test();
        store_count = 0;
        foreach (next_fetch[c]) begin
            next_fetch[c] = test_pc;
            data_due[c]   = 1'b0;
            data_wr[c]    = 1'b0;
        end
        write_dcr(socket_pkg::DCR_START_PC, socket_pkg::data_t'(test_pc));
        write_dcr(socket_pkg::DCR_LAUNCH, '0);
        tick();
        check_busy(busy_s, 1'b1);
        repeat (3) tick();
        check_busy(busy_s, 1'b1);
        // Launch while busy must be dropped
        write_dcr(socket_pkg::DCR_LAUNCH, '0);
        wait_idle();
        foreach (exp_addr[i]) begin
            check_word(exp_addr[i], mem[exp_addr[i]], exp_word[i]);
        end
        check_count(store_count, test_stores);
        if (pending.size() != 0) begin
            abort_run("Memory responses still pending after the cores went idle");
        end
        exp_addr.delete();
        exp_word.delete();
    endtask

    initial begin
        seed          = 32'h8277;
        arst_n        = 1'b0;
        dcr_wr        = 1'b0;
        dcr           = '0;
        mem_ready     = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        cyc           = 0;
        store_count   = 0;
        busy_s        = 1'b0;
        req_s         = 1'b0;
        stalled       = 1'b0;
        stalled_req   = '0;
        test_pc       = '0;
        test_stores   = 0;
        fill_memory();
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Socket stays quiet until launched
        repeat (10) begin
            tick();
            check_busy(busy_s, 1'b0);
            if (req_s) begin
                report_mismatch("memory request before launch");
            end
        end

        fd = $fopen("bench/socket_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open bench/socket_tests.txt");
        end
        done = 1'b0;
        while (!done) begin
            kind = '0;
            rc   = $fscanf(fd, "%s", kind);
            if (rc != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                rc = $fgets(line, fd);
            end else if (kind == "end") begin
                run_test();
                fill_memory();
            end else begin
                rc = $fscanf(fd, "%h %h", fa, fw);
                if (rc != 2) begin
                    abort_run("Malformed line in the test file");
                end
                if (kind == "P") begin
                    mem[socket_pkg::mem_addr_t'(fa)] = fw;
                end else if (kind == "S") begin
                    test_pc     = socket_pkg::mem_addr_t'(fa);
                    test_stores = int'(fw);
                end else if (kind == "E") begin
                    exp_addr.push_back(socket_pkg::mem_addr_t'(fa));
                    exp_word.push_back(fw);
                end else begin
                    abort_run("Unknown line kind in the test file");
                end
            end
        end
        $fclose(fd);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/socket_tests.txt
# kind addr word: P preloads a word, S gives start address and store count (hex),
# E is an expected word after both cores halt, end runs the test
# ADDI, ADD and STORE
P 010 1405
P 011 1903
P 012 2600
P 013 4440
P 014 4841
P 015 0000
S 010 4
E 040 000d
E 041 0008
end
# LOAD of a preloaded word, increment, STORE
P 020 3460
P 021 1501
P 022 4461
P 023 0000
P 060 1234
S 020 2
E 060 1234
E 061 1235
end
# r3 holds the core index, stores land per core
P 030 1710
P 031 19ff
P 032 4770
P 033 4b72
P 034 0000
S 030 4
E 070 0010
E 071 0011
E 072 000f
E 073 0010
end

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int NUM_REGS = 4;
    localparam int IMM_W    = 8;

    typedef logic [1:0] reg_idx_t;

    // Opcode zero halts, so a core running into cleared memory stops
    typedef enum logic [3:0] {
        OP_HALT  = 4'h0,
        OP_ADDI  = 4'h1,
        OP_ADD   = 4'h2,
        OP_LOAD  = 4'h3,
        OP_STORE = 4'h4
    } opcode_t;

    typedef struct packed {
        opcode_t          opcode;
        reg_idx_t         rd;
        reg_idx_t         rs;
        logic [IMM_W-1:0] imm;
    } alu_fmt_t;

    typedef struct packed {
        opcode_t          opcode;
        reg_idx_t         rd;      // Load target or store source
        reg_idx_t         base;
        logic [IMM_W-1:0] offset;
    } mem_fmt_t;

    typedef union packed {
        alu_fmt_t alu;
        mem_fmt_t mem;
    } instr_t;

    typedef struct packed {
        opcode_t           opcode;
        reg_idx_t          rd;
        reg_idx_t          rs;
        socket_pkg::data_t imm;
        logic              is_alu;
        logic              is_mem;
        logic              is_halt;
    } uop_t;

    typedef struct packed {
        reg_idx_t          rd;
        socket_pkg::data_t result;     // ALU value or memory address
        socket_pkg::data_t store_data;
        logic              is_load;
        logic              is_store;
        logic              is_halt;
    } exec_t;

    function automatic socket_pkg::data_t sext(logic [IMM_W-1:0] value);
        return {{(socket_pkg::DATA_W - IMM_W){value[IMM_W-1]}}, value};
    endfunction

endpackage

`default_nettype wire

//--- common/socket_pkg.sv
`default_nettype none

package socket_pkg;

    localparam int NUM_CORES  = 2;
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 16;
    localparam int TAG_W      = 1;
    localparam int DCR_ADDR_W = 2;

    typedef logic [ADDR_W-1:0]     mem_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [DCR_ADDR_W-1:0] dcr_addr_t;

    // External memory port, tag carries the core index
    typedef struct packed {
        logic      wr;
        mem_addr_t addr;
        data_t     wdata;
        tag_t      tag;
    } mem_req_t;

    typedef struct packed {
        data_t data;
        tag_t  tag;
    } mem_rsp_t;

    // Configuration register bus
    typedef struct packed {
        dcr_addr_t addr;
        data_t     data;
    } dcr_req_t;

    localparam dcr_addr_t DCR_START_PC = 2'd0;
    localparam dcr_addr_t DCR_LAUNCH   = 2'd1;

endpackage

`default_nettype wire

//--- core/core.sv
`timescale 1ns/100ps
`default_nettype none

module core #(
    parameter int CORE_ID = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  launch,
    input  socket_pkg::mem_addr_t start_pc,
    output logic                  req_valid,
    output socket_pkg::mem_req_t  req,
    input  logic                  req_taken,
    input  logic                  rsp_valid,
    input  socket_pkg::data_t     rsp_data,
    output logic                  busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT_INSTR,
        S_DECODE,
        S_EXECUTE,
        S_RESULT,       // Data request still waiting for the port
        S_WAIT_DATA
    } state_e;

    state_e                state;
    socket_pkg::mem_addr_t pc;
    core_pkg::uop_t        uop;
    core_pkg::exec_t       exec;
    core_pkg::reg_idx_t    rs_idx;
    core_pkg::reg_idx_t    rd_idx;
    socket_pkg::data_t     rs_val;
    socket_pkg::data_t     rd_val;
    logic                  accept;
    logic                  dec_load;
    logic                  ex_start;
    logic                  res_start;
    logic                  data_req;
    logic                  mem_wr;
    logic                  retire;
    logic                  halted;

    //////////////////////////////////////////////////////////////////////
    // Control

    assign accept    = launch && (state == S_IDLE);
    assign dec_load  = (state == S_WAIT_INSTR) && rsp_valid;
    assign ex_start  = (state == S_DECODE);
    assign res_start = (state == S_EXECUTE);
    assign busy      = (state != S_IDLE) || launch;

    // Data request starts in the result cycle
    assign data_req  = (res_start && (exec.is_load || exec.is_store)) || (state == S_RESULT);
    assign req_valid = ((state == S_FETCH) && !halted) || data_req;

    always_comb begin
        req     = '0;
        req.tag = socket_pkg::tag_t'(CORE_ID);
        if (data_req) begin
            req.wr    = mem_wr;
            req.addr  = exec.result[socket_pkg::ADDR_W-1:0];
            req.wdata = exec.store_data;
        end else begin
            req.addr = pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_FETCH;
                        pc    <= start_pc;
                    end
                end
                S_FETCH: begin
                    if (halted) begin
                        state <= S_IDLE;
                    end else if (req_taken) begin
                        state <= S_WAIT_INSTR;
                    end
                end
                S_WAIT_INSTR: if (rsp_valid) state <= S_DECODE;
                S_DECODE:     state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (retire) begin
                        state <= S_FETCH;
                    end else if (req_taken) begin
                        state <= S_WAIT_DATA;
                    end else begin
                        state <= S_RESULT;
                    end
                end
                S_RESULT:    if (req_taken) state <= S_WAIT_DATA;
                S_WAIT_DATA: if (retire) state <= S_FETCH;
                default:     state <= S_IDLE;
            endcase
            if (retire) begin
                pc <= pc + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stages

    core_decode i_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (dec_load),
        .instr  (core_pkg::instr_t'(rsp_data)),
        .uop    (uop)
    );

    core_execute i_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (ex_start),
        .uop    (uop),
        .rs_val (rs_val),
        .rd_val (rd_val),
        .rs_idx (rs_idx),
        .rd_idx (rd_idx),
        .exec   (exec)
    );

    core_result #(
        .CORE_ID (CORE_ID)
    ) i_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (accept),
        .start     (res_start),
        .exec      (exec),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rs_idx    (rs_idx),
        .rd_idx    (rd_idx),
        .rs_val    (rs_val),
        .rd_val    (rd_val),
        .mem_wr    (mem_wr),
        .retire    (retire),
        .halted    (halted)
    );

    // A pending request holds until the arbiter takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_taken |=> req_valid && $stable(req));

endmodule

`default_nettype wire

//--- core/core_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             load,
    input  core_pkg::instr_t instr,
    output core_pkg::uop_t   uop
);

    core_pkg::uop_t dec;

    always_comb begin
        dec = '0;
        case (instr.alu.opcode)
            core_pkg::OP_ADDI, core_pkg::OP_ADD: begin
                dec.opcode = instr.alu.opcode;
                dec.rd     = instr.alu.rd;
                dec.rs     = instr.alu.rs;
                dec.imm    = core_pkg::sext(instr.alu.imm);
                dec.is_alu = 1'b1;
            end
            core_pkg::OP_LOAD, core_pkg::OP_STORE: begin
                // Base register goes out on the rs read port
                dec.opcode = instr.mem.opcode;
                dec.rd     = instr.mem.rd;
                dec.rs     = instr.mem.base;
                dec.imm    = core_pkg::sext(instr.mem.offset);
                dec.is_mem = 1'b1;
            end
            default: begin
                dec.opcode  = core_pkg::OP_HALT;
                dec.is_halt = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uop <= '0;
        end else if (load) begin
            uop <= dec;
        end
    end

    // One fetch response per instruction, never back to back
    a_single_load: assert property (@(posedge clk) disable iff (!arst_n) load |=> !load);

endmodule

`default_nettype wire

//--- core/core_execute.sv
`timescale 1ns/100ps
`default_nettype none

module core_execute (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  core_pkg::uop_t      uop,
    input  socket_pkg::data_t   rs_val,
    input  socket_pkg::data_t   rd_val,
    output core_pkg::reg_idx_t  rs_idx,
    output core_pkg::reg_idx_t  rd_idx,
    output core_pkg::exec_t     exec
);

    core_pkg::exec_t nxt;

    // Register reads follow the held micro-op
    assign rs_idx = uop.rs;
    assign rd_idx = uop.rd;

    always_comb begin
        nxt          = '0;
        nxt.rd       = uop.rd;
        nxt.is_load  = uop.is_mem && (uop.opcode == core_pkg::OP_LOAD);
        nxt.is_store = uop.is_mem && (uop.opcode == core_pkg::OP_STORE);
        nxt.is_halt  = uop.is_halt;
        if (uop.is_alu) begin
            if (uop.opcode == core_pkg::OP_ADD) begin
                nxt.result = rd_val + rs_val;
            end else begin
                nxt.result = rs_val + uop.imm;
            end
        end else if (uop.is_mem) begin
            // Address is base plus offset
            nxt.result     = rs_val + uop.imm;
            nxt.store_data = rd_val;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec <= '0;
        end else if (start) begin
            exec <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- core/core_result.sv
`timescale 1ns/100ps
`default_nettype none

module core_result #(
    parameter int CORE_ID = 0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clear,
    input  logic               start,
    input  core_pkg::exec_t    exec,
    input  logic               rsp_valid,
    input  socket_pkg::data_t  rsp_data,
    input  core_pkg::reg_idx_t rs_idx,
    input  core_pkg::reg_idx_t rd_idx,
    output socket_pkg::data_t  rs_val,
    output socket_pkg::data_t  rd_val,
    output logic               mem_wr,
    output logic               retire,
    output logic               halted
);

    socket_pkg::data_t regs [core_pkg::NUM_REGS];
    logic              pending;
    logic              is_mem;
    logic              alu_wb;
    logic              load_wb;

    assign is_mem  = exec.is_load || exec.is_store;
    assign alu_wb  = start && !is_mem && !exec.is_halt;
    assign load_wb = pending && rsp_valid && exec.is_load;

    // ALU ops and HALT retire at once, memory ops on their response
    assign retire = (start && !is_mem) || (pending && rsp_valid);
    assign mem_wr = exec.is_store;

    assign rs_val = regs[rs_idx];
    assign rd_val = regs[rd_idx];

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            // r3 holds the core index after launch
            regs[core_pkg::NUM_REGS-1] <= socket_pkg::data_t'(CORE_ID);
        end else if (alu_wb) begin
            regs[exec.rd] <= exec.result;
        end else if (load_wb) begin
            regs[exec.rd] <= rsp_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            halted  <= 1'b0;
        end else if (clear) begin
            pending <= 1'b0;
            halted  <= 1'b0;
        end else begin
            if (start && is_mem) begin
                pending <= 1'b1;
            end else if (rsp_valid) begin
                pending <= 1'b0;
            end
            if (start && exec.is_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_arb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arb (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [socket_pkg::NUM_CORES-1:0]    core_req_valid,
    input  socket_pkg::mem_req_t                core_req [socket_pkg::NUM_CORES],
    output logic [socket_pkg::NUM_CORES-1:0]    core_req_taken,
    output logic [socket_pkg::NUM_CORES-1:0]    core_rsp_valid,
    output logic                                mem_req_valid,
    output socket_pkg::mem_req_t                mem_req,
    input  logic                                mem_ready,
    input  logic                                mem_rsp_valid,
    input  socket_pkg::mem_rsp_t                mem_rsp,
    output socket_pkg::data_t                   rsp_data
);

    socket_pkg::tag_t ptr;
    socket_pkg::tag_t pick;
    socket_pkg::tag_t grant;
    socket_pkg::tag_t hold_idx;
    logic             pick_any;
    logic             hold_q;
    logic             taken;

    //////////////////////////////////////////////////////////////////////
    // Round-robin pick starting at the pointer

    always_comb begin
        int idx;
        pick_any = 1'b0;
        pick     = ptr;
        // Walk backwards so the nearest valid core wins
        for (int i = socket_pkg::NUM_CORES - 1; i >= 0; i--) begin
            idx = (int'(ptr) + i) % socket_pkg::NUM_CORES;
            if (core_req_valid[idx]) begin
                pick_any = 1'b1;
                pick     = socket_pkg::tag_t'(idx);
            end
        end
    end

    // A stalled grant stays locked until the memory takes it
    assign grant         = hold_q ? hold_idx : pick;
    assign mem_req_valid = hold_q || pick_any;
    assign mem_req       = core_req[grant];
    assign taken         = mem_req_valid && mem_ready;
    assign rsp_data      = mem_rsp.data;

    for (genvar i = 0; i < socket_pkg::NUM_CORES; i++) begin : g_port
        assign core_req_taken[i] = taken && (grant == socket_pkg::tag_t'(i));
        assign core_rsp_valid[i] = mem_rsp_valid && (mem_rsp.tag == socket_pkg::tag_t'(i));
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr      <= '0;
            hold_q   <= 1'b0;
            hold_idx <= '0;
        end else if (taken) begin
            hold_q <= 1'b0;
            if (grant == socket_pkg::tag_t'(socket_pkg::NUM_CORES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant + 1'b1;
            end
        end else if (mem_req_valid) begin
            hold_q   <= 1'b1;
            hold_idx <= grant;
        end
    end

    // One grant per cycle and only to a core that is asking
    a_one_taken: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(core_req_taken) && ((core_req_taken & ~core_req_valid) == '0));

endmodule

`default_nettype wire

//--- design/socket_top.sv
`timescale 1ns/100ps
`default_nettype none

module socket_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 dcr_wr,
    input  socket_pkg::dcr_req_t dcr,
    output logic                 mem_req_valid,
    output socket_pkg::mem_req_t mem_req,
    input  logic                 mem_ready,
    input  logic                 mem_rsp_valid,
    input  socket_pkg::mem_rsp_t mem_rsp,
    output logic                 busy
);

    socket_pkg::mem_addr_t                start_pc;
    logic                                 launch;
    logic [socket_pkg::NUM_CORES-1:0]     core_busy;
    logic [socket_pkg::NUM_CORES-1:0]     core_req_valid;
    logic [socket_pkg::NUM_CORES-1:0]     core_req_taken;
    logic [socket_pkg::NUM_CORES-1:0]     core_rsp_valid;
    socket_pkg::mem_req_t                 core_req [socket_pkg::NUM_CORES];
    socket_pkg::data_t                    rsp_data;

    //////////////////////////////////////////////////////////////////////
    // Configuration registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_pc <= '0;
            launch   <= 1'b0;
        end else begin
            // Launch pulse one cycle after the write, dropped while busy
            launch <= dcr_wr && (dcr.addr == socket_pkg::DCR_LAUNCH) && !busy;
            if (dcr_wr && (dcr.addr == socket_pkg::DCR_START_PC)) begin
                start_pc <= dcr.data[socket_pkg::ADDR_W-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Cores and memory arbiter

    for (genvar i = 0; i < socket_pkg::NUM_CORES; i++) begin : g_core
        core #(
            .CORE_ID (i)
        ) i_core (
            .clk       (clk),
            .arst_n    (arst_n),
            .launch    (launch),
            .start_pc  (start_pc),
            .req_valid (core_req_valid[i]),
            .req       (core_req[i]),
            .req_taken (core_req_taken[i]),
            .rsp_valid (core_rsp_valid[i]),
            .rsp_data  (rsp_data),
            .busy      (core_busy[i])
        );
    end

    mem_arb i_mem_arb (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_taken (core_req_taken),
        .core_rsp_valid (core_rsp_valid),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .rsp_data       (rsp_data)
    );

    assign busy = |core_busy;

endmodule

`default_nettype wire

//--- mini_socket.f
common/socket_pkg.sv
common/core_pkg.sv
core/core_decode.sv
core/core_execute.sv
core/core_result.sv
core/core.sv
design/mem_arb.sv
design/socket_top.sv
bench/socket_tb.sv
